// File: vid_mem_arbiter.f
common/vid_arb_pkg.sv
arbiter/burst_sched.sv
arbiter/mem_cmd_gen.sv
logic/frame_writer.sv
logic/frame_queue.sv
logic/vid_mem_arbiter.sv
bench/mem_model.sv
bench/vid_mem_arbiter_tb.sv

// File: Bender.yml
package:
  name: vid_mem_arbiter

sources:
  - common/vid_arb_pkg.sv
  - arbiter/burst_sched.sv
  - arbiter/mem_cmd_gen.sv
  - logic/frame_writer.sv
  - logic/frame_queue.sv
  - logic/vid_mem_arbiter.sv
  - target: simulation
    files:
      - bench/mem_model.sv
      - bench/vid_mem_arbiter_tb.sv

// File: bench/vid_mem_arbiter_tb.sv
module vid_mem_arbiter_tb
  import vid_arb_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ADDR_WIDTH     = 25;
  localparam int BURST_LEN      = 16;
  localparam int NUM_SLOTS      = 4;
  localparam int SLOT_BURSTS    = 64;
  localparam int NUM_FRAMES     = 40;
  localparam int MAX_BURSTS     = 8;
  localparam int BURST_BYTES    = BURST_LEN * BEAT_BYTES;
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * MAX_BURSTS * 4 * BURST_LEN + 2000;

  logic                  clk;
  logic                  rst;
  logic                  v_burst_avail;
  logic                  v_rd_en;
  vid_word_t             v_rd_data;
  mem_cmd_t              mem_cmd;
  logic [DATA_WIDTH-1:0] mem_wr_data;
  logic                  mem_cmd_rdy;
  logic [DATA_WIDTH-1:0] mem_rd_data;
  logic                  mem_rd_valid;
  logic                  rfifo_full;
  logic                  rfifo_wr_en;
  vid_word_t             rfifo_wr_data;
  logic                  disp_avail;
  logic [2:0]            mem_lat;
  logic                  mem_stall;

  // Reference model state
  logic [31:0] rng;
  vid_word_t   vid_q[$];
  vid_word_t   exp_q[$];
  int          frame_len[NUM_FRAMES];
  int          wr_frame = 0;
  int          wr_burst = 0;
  int          rd_frame = 0;
  int          rd_burst = 0;
  int          wr_run = 0;
  int          frames_started = 0;
  int          frames_read = 0;
  int          drain = 0;
  int          cycle_cnt = 0;
  logic [1:0]  rdy_hist;
  logic [1:0]  full_hist;

  vid_mem_arbiter #(
    .ADDR_WIDTH      (ADDR_WIDTH),
    .BURST_LEN       (BURST_LEN),
    .NUM_SLOTS       (NUM_SLOTS),
    .SLOT_BURSTS     (SLOT_BURSTS)
  ) i_dut (
    .clk             (clk),
    .rst             (rst),
    .i_v_burst_avail (v_burst_avail),
    .o_v_rd_en       (v_rd_en),
    .i_v_rd_data     (v_rd_data),
    .o_mem_cmd       (mem_cmd),
    .o_mem_wr_data   (mem_wr_data),
    .i_mem_cmd_rdy   (mem_cmd_rdy),
    .i_mem_rd_data   (mem_rd_data),
    .i_mem_rd_valid  (mem_rd_valid),
    .i_rfifo_full    (rfifo_full),
    .o_rfifo_wr_en   (rfifo_wr_en),
    .o_rfifo_wr_data (rfifo_wr_data),
    .o_disp_avail    (disp_avail)
  );

  mem_model #(
    .BURST_LEN  (BURST_LEN),
    .MEM_WORDS  (NUM_SLOTS * SLOT_BURSTS * BURST_LEN)
  ) u_mem (
    .clk        (clk),
    .rst        (rst),
    .i_cmd      (mem_cmd),
    .i_wr_data  (mem_wr_data),
    .i_lat      (mem_lat),
    .i_stall    (mem_stall),
    .o_rd_data  (mem_rd_data),
    .o_rd_valid (mem_rd_valid)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // ========================================
  // Helpers
  // ========================================
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Slot base plus burst offset, slots taken in frame order
  function automatic logic [31:0] expected_addr(input int frame, input int burst);
    int slot_base;
    slot_base = (frame % NUM_SLOTS) * SLOT_BURSTS * BURST_BYTES;
    return 32'(slot_base + burst * BURST_BYTES);
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic make_frames();
    vid_word_t word;
    int        words;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      rng = xorshift32(rng);
      frame_len[f] = 1 + int'(rng % MAX_BURSTS);
      words = frame_len[f] * BURST_LEN;
      for (int w = 0; w < words; w++) begin
        rng = xorshift32(rng);
        word.data = rng;
        word.sof  = (w == 0);
        word.eof  = (w == words - 1);
        vid_q.push_back(word);
        exp_q.push_back(word);
      end
    end
  endtask

  task automatic drive_inputs();
    rng = xorshift32(rng);
    // Tail beat of a running burst is not available for the next one
    v_burst_avail = (vid_q.size() >= BURST_LEN + int'(v_rd_en)) && (rng[2:0] != 3'd0);
    mem_cmd_rdy   = (rng[5:3] != 3'd0);
    rfifo_full    = (rng[9:7] == 3'd0);
    mem_stall     = (rng[11:10] == 2'd0);
    mem_lat       = rng[14:12];
    if (vid_q.size() > 0) begin
      v_rd_data = vid_q[0];
    end else begin
      v_rd_data = '0;
    end
  endtask

  // ========================================
  // Per-cycle checks, sampled at the falling edge
  // ========================================
  task automatic check_cycle();
    vid_word_t   head;
    vid_word_t   want;
    logic [31:0] addr;
    assert (v_rd_en == mem_cmd.wr_en)
      else fail_run($sformatf("[ERROR] o_v_rd_en: got 0x%h, expected 0x%h",
                              v_rd_en, mem_cmd.wr_en));
    if (mem_cmd.wr_en) begin
      wr_run++;
      if (wr_run == 1) begin
        assert (mem_cmd.cmd_en && mem_cmd.wr)
          else fail_run("Write burst began without a write command");
      end else begin
        assert (!mem_cmd.cmd_en) else fail_run("Command enable high inside a write burst");
      end
      assert (wr_run <= BURST_LEN) else fail_run("Write enable held longer than one burst");
    end else begin
      assert (wr_run == 0 || wr_run == BURST_LEN)
        else fail_run($sformatf("Write burst ended after %0d beats", wr_run));
      assert (!(mem_cmd.cmd_en && mem_cmd.wr)) else fail_run("Write command without write enable");
      wr_run = 0;
    end

    // Decision was taken two cycles before the command
    if (mem_cmd.cmd_en) begin
      assert (rdy_hist[1]) else fail_run("Command issued although memory was not ready");
      if (mem_cmd.wr) begin
        addr = expected_addr(wr_frame, wr_burst);
        assert (mem_cmd.addr == addr)
          else fail_run($sformatf("[ERROR] o_mem_cmd.addr: got 0x%h, expected 0x%h",
                                  mem_cmd.addr, addr));
        wr_burst++;
      end else begin
        assert (!full_hist[1]) else fail_run("Read started while the display FIFO was full");
        assert (rd_frame < NUM_FRAMES) else fail_run("Read command with no frame left to read");
        addr = expected_addr(rd_frame, rd_burst);
        assert (mem_cmd.addr == addr)
          else fail_run($sformatf("[ERROR] o_mem_cmd.addr: got 0x%h, expected 0x%h",
                                  mem_cmd.addr, addr));
        rd_burst++;
        if (rd_burst == frame_len[rd_frame]) begin
          rd_frame++;
          rd_burst = 0;
        end
      end
    end

    if (v_rd_en) begin
      assert (vid_q.size() > 0) else fail_run("Video FIFO read while empty");
      head = vid_q.pop_front();
      assert (mem_wr_data == head.data)
        else fail_run($sformatf("[ERROR] o_mem_wr_data: got 0x%h, expected 0x%h",
                                mem_wr_data, head.data));
      if (head.sof) begin
        frames_started++;
      end
      if (head.eof) begin
        wr_frame++;
        wr_burst = 0;
      end
    end

    if (rfifo_wr_en) begin
      assert (exp_q.size() > 0) else fail_run("Display word written with no frame pending");
      want = exp_q.pop_front();
      assert (rfifo_wr_data == want)
        else fail_run($sformatf("[ERROR] o_rfifo_wr_data: got 0x%h, expected 0x%h",
                                rfifo_wr_data, want));
      if (want.eof) begin
        frames_read++;
      end
    end
    assert (frames_started - frames_read <= NUM_SLOTS)
      else fail_run("More frames held in memory than there are slots");

    rdy_hist  = {rdy_hist[0], mem_cmd_rdy};
    full_hist = {full_hist[0], rfifo_full};
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    rng           = 32'hb294;
    rst           = 1'b1;
    v_burst_avail = 1'b0;
    v_rd_data     = '0;
    mem_cmd_rdy   = 1'b1;
    rfifo_full    = 1'b0;
    mem_stall     = 1'b0;
    mem_lat       = '0;
    rdy_hist      = 2'b11;
    full_hist     = 2'b00;
    make_frames();
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    assert (!v_rd_en && !mem_cmd.cmd_en && !mem_cmd.wr_en && !rfifo_wr_en && !disp_avail)
      else fail_run("Control outputs not low after reset");

    // Run until every frame is displayed, then a few idle cycles
    while (exp_q.size() > 0 || drain < 8) begin
      @(posedge clk);
      #1;
      drive_inputs();
      @(negedge clk);
      check_cycle();
      if (exp_q.size() == 0) begin
        drain++;
      end
    end

    assert (vid_q.size() == 0) else fail_run("Video words left unsent at the end");
    assert (rd_frame == NUM_FRAMES) else fail_run("Not every frame was read back");
    assert (!disp_avail)
      else fail_run($sformatf("[ERROR] o_disp_avail: got 0x%h, expected 0x0", disp_avail));
    $display("Finished with no errors");
    $finish;
  end

  // Run limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      fail_run($sformatf("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

endmodule

// File: bench/mem_model.sv
module mem_model
  import vid_arb_pkg::*;
#(
  parameter int BURST_LEN = 16,
  parameter int MEM_WORDS = 4096
) (
  input  logic                  clk,
  input  logic                  rst,
  input  mem_cmd_t              i_cmd,
  input  logic [DATA_WIDTH-1:0] i_wr_data,
  input  logic [2:0]            i_lat,
  input  logic                  i_stall,
  output logic [DATA_WIDTH-1:0] o_rd_data,
  output logic                  o_rd_valid
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [DATA_WIDTH-1:0]     mem [MEM_WORDS];
  logic [MAX_ADDR_WIDTH-1:0] wr_base;
  int unsigned               wr_idx;
  logic [MAX_ADDR_WIDTH-1:0] rd_base;
  int unsigned               rd_idx;
  int unsigned               rd_left;
  int unsigned               rd_wait;

  function automatic int unsigned word_index(input logic [MAX_ADDR_WIDTH-1:0] addr);
    return (addr / BEAT_BYTES) % MEM_WORDS;
  endfunction

  // Unwritten words read back as a pattern of their byte address
  initial begin
    o_rd_valid = 1'b0;
    o_rd_data  = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'(i * BEAT_BYTES) ^ 32'ha5c3_0f96;
    end
  end

  // ========================================
  // Command and data handling
  // ========================================
  always @(posedge clk) begin
    if (rst) begin
      wr_idx  = 0;
      rd_idx  = 0;
      rd_left = 0;
      rd_wait = 0;
      o_rd_valid <= #1 1'b0;
    end else begin
      // First write beat rides with the command
      if (i_cmd.cmd_en && i_cmd.wr) begin
        wr_base = i_cmd.addr;
        wr_idx  = 0;
      end
      if (i_cmd.wr_en) begin
        mem[word_index(wr_base + wr_idx * BEAT_BYTES)] = i_wr_data;
        wr_idx++;
      end
      if (i_cmd.cmd_en && !i_cmd.wr) begin
        rd_base = i_cmd.addr;
        rd_idx  = 0;
        rd_left = BURST_LEN;
        rd_wait = i_lat;
      end
      // Read beats after the latency, with random gaps
      if (rd_left > 0 && rd_wait == 0 && !i_stall) begin
        o_rd_data  <= #1 mem[word_index(rd_base + rd_idx * BEAT_BYTES)];
        o_rd_valid <= #1 1'b1;
        rd_idx++;
        rd_left--;
      end else begin
        o_rd_valid <= #1 1'b0;
        if (rd_wait > 0) begin
          rd_wait--;
        end
      end
    end
  end

endmodule

// File: logic/vid_mem_arbiter.sv
module vid_mem_arbiter
  import vid_arb_pkg::*;
#(
  parameter int ADDR_WIDTH  = 25,
  parameter int BURST_LEN   = 16,
  parameter int NUM_SLOTS   = 4,
  parameter int SLOT_BURSTS = 64
) (
  input  logic                  clk,
  input  logic                  rst,
  // Upstream video FIFO
  input  logic                  i_v_burst_avail,
  output logic                  o_v_rd_en,
  input  vid_word_t             i_v_rd_data,
  // Memory port
  output mem_cmd_t              o_mem_cmd,
  output logic [DATA_WIDTH-1:0] o_mem_wr_data,
  input  logic                  i_mem_cmd_rdy,
  input  logic [DATA_WIDTH-1:0] i_mem_rd_data,
  input  logic                  i_mem_rd_valid,
  // Display FIFO
  input  logic                  i_rfifo_full,
  output logic                  o_rfifo_wr_en,
  output vid_word_t             o_rfifo_wr_data,
  output logic                  o_disp_avail
);

  burst_state_e          state;
  logic                  burst_start;
  logic                  rd_done;
  logic                  wr_ready;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic                  desc_valid;
  frame_desc_t           desc;
  logic                  slot_release;

  burst_sched #(
    .BURST_LEN       (BURST_LEN)
  ) u_burst_sched (
    .clk             (clk),
    .rst             (rst),
    .i_mem_cmd_rdy   (i_mem_cmd_rdy),
    .i_v_burst_avail (i_v_burst_avail),
    .i_wr_ready      (wr_ready),
    .i_disp_avail    (o_disp_avail),
    .i_rfifo_full    (i_rfifo_full),
    .i_mem_rd_valid  (i_mem_rd_valid),
    .o_state         (state),
    .o_burst_start   (burst_start),
    .o_v_rd_en       (o_v_rd_en),
    .o_rd_done       (rd_done)
  );

  mem_cmd_gen #(
    .ADDR_WIDTH    (ADDR_WIDTH)
  ) u_mem_cmd_gen (
    .clk           (clk),
    .rst           (rst),
    .i_state       (state),
    .i_burst_start (burst_start),
    .i_wr_addr     (wr_addr),
    .i_rd_addr     (rd_addr),
    .i_v_rd_data   (i_v_rd_data),
    .o_mem_cmd     (o_mem_cmd),
    .o_mem_wr_data (o_mem_wr_data)
  );

  frame_writer #(
    .ADDR_WIDTH     (ADDR_WIDTH),
    .BURST_LEN      (BURST_LEN),
    .NUM_SLOTS      (NUM_SLOTS),
    .SLOT_BURSTS    (SLOT_BURSTS)
  ) u_frame_writer (
    .clk            (clk),
    .rst            (rst),
    .i_v_rd_en      (o_v_rd_en),
    .i_v_rd_data    (i_v_rd_data),
    .i_burst_start  (burst_start),
    .i_state        (state),
    .i_slot_release (slot_release),
    .o_wr_addr      (wr_addr),
    .o_wr_ready     (wr_ready),
    .o_desc_valid   (desc_valid),
    .o_desc         (desc)
  );

  frame_queue #(
    .ADDR_WIDTH      (ADDR_WIDTH),
    .BURST_LEN       (BURST_LEN),
    .NUM_SLOTS       (NUM_SLOTS),
    .SLOT_BURSTS     (SLOT_BURSTS)
  ) u_frame_queue (
    .clk             (clk),
    .rst             (rst),
    .i_desc_valid    (desc_valid),
    .i_desc          (desc),
    .i_rd_done       (rd_done),
    .i_state         (state),
    .i_mem_rd_valid  (i_mem_rd_valid),
    .i_mem_rd_data   (i_mem_rd_data),
    .o_disp_avail    (o_disp_avail),
    .o_rd_addr       (rd_addr),
    .o_slot_release  (slot_release),
    .o_rfifo_wr_en   (o_rfifo_wr_en),
    .o_rfifo_wr_data (o_rfifo_wr_data)
  );

endmodule

// File: logic/frame_queue.sv
module frame_queue
  import vid_arb_pkg::*;
#(
  parameter int ADDR_WIDTH  = 25,
  parameter int BURST_LEN   = 16,
  parameter int NUM_SLOTS   = 4,
  parameter int SLOT_BURSTS = 64
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_desc_valid,
  input  frame_desc_t           i_desc,
  input  logic                  i_rd_done,
  input  burst_state_e          i_state,
  input  logic                  i_mem_rd_valid,
  input  logic [DATA_WIDTH-1:0] i_mem_rd_data,
  output logic                  o_disp_avail,
  output logic [ADDR_WIDTH-1:0] o_rd_addr,
  output logic                  o_slot_release,
  output logic                  o_rfifo_wr_en,
  output vid_word_t             o_rfifo_wr_data
);

  localparam int PTR_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;
  localparam int CNT_W = $clog2(NUM_SLOTS + 1);

  frame_desc_t      desc_mem [NUM_SLOTS];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] q_cnt;
  frame_desc_t      head;
  logic [7:0]       rd_burst;
  logic             last_burst;
  logic             pop;
  logic             rd_beat;
  logic             beat_seen;

  // ========================================
  // Descriptor FIFO
  // ========================================
  always_ff @(posedge clk) begin
    if (i_desc_valid) begin
      desc_mem[wr_ptr] <= i_desc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (i_desc_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(NUM_SLOTS - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(NUM_SLOTS - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      q_cnt <= '0;
    end else begin
      case ({i_desc_valid, pop})
        2'b10:   q_cnt <= q_cnt + 1'b1;
        2'b01:   q_cnt <= q_cnt - 1'b1;
        default: q_cnt <= q_cnt;
      endcase
    end
  end

  assign head         = desc_mem[rd_ptr];
  assign o_disp_avail = (q_cnt != '0);

  // ========================================
  // Read address walk
  // ========================================
  assign last_burst = (rd_burst == head.bursts - 8'd1);
  assign pop        = i_rd_done && last_burst;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_burst <= '0;
    end else if (i_rd_done) begin
      if (last_burst) begin
        rd_burst <= '0;
      end else begin
        rd_burst <= rd_burst + 1'b1;
      end
    end
  end

  assign o_rd_addr      = ADDR_WIDTH'(burst_addr(head.slot, rd_burst, BURST_LEN, SLOT_BURSTS));
  // Slot is free once its last burst is back
  assign o_slot_release = pop;

  // ========================================
  // Display word tagging
  // ========================================
  assign rd_beat = i_mem_rd_valid && (i_state == ST_RD_BURST);

  // Marks that the current burst already returned a beat
  always_ff @(posedge clk) begin
    if (rst || i_rd_done) begin
      beat_seen <= 1'b0;
    end else if (rd_beat) begin
      beat_seen <= 1'b1;
    end
  end

  assign o_rfifo_wr_en   = rd_beat;
  assign o_rfifo_wr_data = '{
    eof:  rd_beat && pop,
    sof:  rd_beat && (rd_burst == 8'd0) && !beat_seen,
    data: i_mem_rd_data
  };

endmodule

// File: logic/frame_writer.sv
module frame_writer
  import vid_arb_pkg::*;
#(
  parameter int ADDR_WIDTH  = 25,
  parameter int BURST_LEN   = 16,
  parameter int NUM_SLOTS   = 4,
  parameter int SLOT_BURSTS = 64
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_v_rd_en,
  input  vid_word_t             i_v_rd_data,
  input  logic                  i_burst_start,
  input  burst_state_e          i_state,
  input  logic                  i_slot_release,
  output logic [ADDR_WIDTH-1:0] o_wr_addr,
  output logic                  o_wr_ready,
  output logic                  o_desc_valid,
  output frame_desc_t           o_desc
);

  localparam int SLOT_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;
  localparam int BIDX_W = (SLOT_BURSTS > 1) ? $clog2(SLOT_BURSTS) : 1;
  localparam int OCC_W  = $clog2(NUM_SLOTS + 1);

  logic              wr_sof;
  logic              wr_eof;
  logic              wr_start;
  logic [SLOT_W-1:0] slot;
  logic [BIDX_W-1:0] burst_idx;
  logic [7:0]        frm_bursts;
  logic              in_progress;
  logic [OCC_W-1:0]  occ_cnt;

  // ========================================
  // Sideband flags
  // ========================================
  assign wr_sof   = i_v_rd_en & i_v_rd_data.sof;
  assign wr_eof   = i_v_rd_en & i_v_rd_data.eof;
  assign wr_start = i_burst_start && (i_state == ST_WR_BURST);

  // ========================================
  // Write address walk
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      slot      <= '0;
      burst_idx <= '0;
    end else if (wr_eof) begin
      // Next frame goes to the next slot base
      burst_idx <= '0;
      if (slot == SLOT_W'(NUM_SLOTS - 1)) begin
        slot <= '0;
      end else begin
        slot <= slot + 1'b1;
      end
    end else if (wr_start) begin
      // Oversized frames wrap inside their slot
      if (burst_idx == BIDX_W'(SLOT_BURSTS - 1)) begin
        burst_idx <= '0;
      end else begin
        burst_idx <= burst_idx + 1'b1;
      end
    end
  end

  assign o_wr_addr = ADDR_WIDTH'(burst_addr(slot, burst_idx, BURST_LEN, SLOT_BURSTS));

  // Frame length in bursts, capped at the slot size
  always_ff @(posedge clk) begin
    if (rst || wr_eof) begin
      frm_bursts <= '0;
    end else if (wr_start && frm_bursts != 8'(SLOT_BURSTS)) begin
      frm_bursts <= frm_bursts + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || wr_eof) begin
      in_progress <= 1'b0;
    end else if (wr_sof) begin
      in_progress <= 1'b1;
    end
  end

  // ========================================
  // Slot occupancy
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      occ_cnt <= '0;
    end else begin
      case ({o_desc_valid, i_slot_release})
        2'b10:   occ_cnt <= occ_cnt + 1'b1;
        2'b01:   occ_cnt <= occ_cnt - 1'b1;
        default: occ_cnt <= occ_cnt;
      endcase
    end
  end

  // Held low on the end-of-frame beat while the count catches up
  assign o_wr_ready = !wr_eof && (in_progress || occ_cnt < OCC_W'(NUM_SLOTS));

  assign o_desc_valid = wr_eof;
  assign o_desc       = '{slot: 8'(slot), bursts: frm_bursts};

endmodule

// File: arbiter/mem_cmd_gen.sv
module mem_cmd_gen
  import vid_arb_pkg::*;
#(
  parameter int ADDR_WIDTH = 25
) (
  input  logic                  clk,
  input  logic                  rst,
  input  burst_state_e          i_state,
  input  logic                  i_burst_start,
  input  logic [ADDR_WIDTH-1:0] i_wr_addr,
  input  logic [ADDR_WIDTH-1:0] i_rd_addr,
  input  vid_word_t             i_v_rd_data,
  output mem_cmd_t              o_mem_cmd,
  output logic [DATA_WIDTH-1:0] o_mem_wr_data
);

  logic                  is_wr;
  logic                  cmd_en;
  logic                  cmd_wr;
  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] cmd_addr;

  assign is_wr = (i_state == ST_WR_BURST);

  // ========================================
  // Memory control
  // ========================================
  // Command enable lasts one cycle, write enable spans the burst
  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_en <= 1'b0;
      cmd_wr <= 1'b0;
      wr_en  <= 1'b0;
    end else begin
      cmd_en <= i_burst_start;
      cmd_wr <= i_burst_start && is_wr;
      wr_en  <= is_wr;
    end
  end

  // Address latched with the command
  always_ff @(posedge clk) begin
    if (i_burst_start) begin
      if (is_wr) begin
        cmd_addr <= i_wr_addr;
      end else begin
        cmd_addr <= i_rd_addr;
      end
    end
  end

  assign o_mem_cmd = '{
    addr:   MAX_ADDR_WIDTH'(cmd_addr),
    wr:     cmd_wr,
    cmd_en: cmd_en,
    wr_en:  wr_en
  };

  // FWFT source, payload is valid with the read enable
  assign o_mem_wr_data = i_v_rd_data.data;

endmodule

// File: arbiter/burst_sched.sv
module burst_sched
  import vid_arb_pkg::*;
#(
  parameter int BURST_LEN = 16
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         i_mem_cmd_rdy,
  input  logic         i_v_burst_avail,
  input  logic         i_wr_ready,
  input  logic         i_disp_avail,
  input  logic         i_rfifo_full,
  input  logic         i_mem_rd_valid,
  output burst_state_e o_state,
  output logic         o_burst_start,
  output logic         o_v_rd_en,
  output logic         o_rd_done
);

  localparam int CNT_W = $clog2(BURST_LEN) + 1;

  burst_state_e     state;
  burst_state_e     state_nxt;
  logic [CNT_W-1:0] wr_beat_cnt;
  logic [CNT_W-1:0] rd_beat_cnt;
  logic             wr_last;

  // ========================================
  // Burst beat counters
  // ========================================
  // Write beats follow the state one cycle late, so count cycles in state
  always_ff @(posedge clk) begin
    if (rst || state != ST_WR_BURST) begin
      wr_beat_cnt <= '0;
    end else begin
      wr_beat_cnt <= wr_beat_cnt + 1'b1;
    end
  end

  assign wr_last = (state == ST_WR_BURST) && (wr_beat_cnt == CNT_W'(BURST_LEN - 1));

  // Returned read beats, may arrive with gaps
  always_ff @(posedge clk) begin
    if (rst || o_rd_done) begin
      rd_beat_cnt <= '0;
    end else if (state == ST_RD_BURST && i_mem_rd_valid) begin
      rd_beat_cnt <= rd_beat_cnt + 1'b1;
    end
  end

  assign o_rd_done = (state == ST_RD_BURST) && i_mem_rd_valid &&
                     (rd_beat_cnt == CNT_W'(BURST_LEN - 1));

  // ========================================
  // Arbiter FSM
  // ========================================
  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        // Video writes first, then display reads
        if (i_mem_cmd_rdy) begin
          if (i_v_burst_avail && i_wr_ready) begin
            state_nxt = ST_WR_BURST;
          end else if (i_disp_avail) begin
            state_nxt = ST_RD_IDLE;
          end
        end
      end
      ST_WR_BURST: begin
        if (wr_last) begin
          state_nxt = ST_IDLE;
        end
      end
      ST_RD_IDLE: begin
        // Display FIFO near full, give the port back
        if (i_rfifo_full) begin
          state_nxt = ST_IDLE;
        end else if (i_mem_cmd_rdy) begin
          state_nxt = ST_RD_BURST;
        end
      end
      ST_RD_BURST: begin
        if (o_rd_done) begin
          state_nxt = ST_IDLE;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= ST_IDLE;
      o_burst_start <= 1'b0;
      o_v_rd_en     <= 1'b0;
    end else begin
      state         <= state_nxt;
      // First cycle of either burst state
      o_burst_start <= (state_nxt != state) &&
                       (state_nxt == ST_WR_BURST || state_nxt == ST_RD_BURST);
      o_v_rd_en     <= (state == ST_WR_BURST);
    end
  end

  assign o_state = state;

endmodule

// File: common/vid_arb_pkg.sv
package vid_arb_pkg;

  // ========================================
  // Widths and fixed constants
  // ========================================
  // Pixel payload of one memory beat
  localparam int DATA_WIDTH = 32;

  // Bytes per beat, addresses are byte addresses
  localparam int BEAT_BYTES = 4;

  // Widest memory address the command struct can carry
  localparam int MAX_ADDR_WIDTH = 32;

  // ========================================
  // Shared types
  // ========================================
  // One video word with sideband frame flags
  typedef struct packed {
    logic                  eof;
    logic                  sof;
    logic [DATA_WIDTH-1:0] data;
  } vid_word_t;

  // Burst scheduler states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WR_BURST,
    ST_RD_IDLE,
    ST_RD_BURST
  } burst_state_e;

  // Memory command, low ADDR_WIDTH bits of addr are used
  typedef struct packed {
    logic [MAX_ADDR_WIDTH-1:0] addr;
    logic                      wr;
    logic                      cmd_en;
    logic                      wr_en;
  } mem_cmd_t;

  // Frame descriptor queue entry
  typedef struct packed {
    logic [7:0] slot;
    logic [7:0] bursts;
  } frame_desc_t;

  // Byte address of a burst inside a frame slot
  function automatic logic [MAX_ADDR_WIDTH-1:0] burst_addr(
    input int unsigned slot,
    input int unsigned burst,
    input int unsigned burst_len,
    input int unsigned slot_bursts
  );
    return MAX_ADDR_WIDTH'((slot * slot_bursts + burst) * burst_len * BEAT_BYTES);
  endfunction

endpackage
